// File: flist.f
+incdir+rtl
rtl/enigma_pkg.sv
rtl/enigma_plugboard.sv
rtl/enigma_rotor.sv
rtl/enigma_whitening.sv
rtl/enigma_top.sv
sim/enigma_tb.sv

// File: rtl/enigma_consts.svh
/*
 * Enigma cipher constants
 * character width, table depths, whitening seed and pipeline latency
 */

`ifndef ENIGMA_CONSTS_SVH
`define ENIGMA_CONSTS_SVH

// character and rotor offset width
`define ENIGMA_CODE_W 6

// table depths
`define ENIGMA_ROTOR_DEPTH 64
`define ENIGMA_PLUG_DEPTH 32

// whitening LFSR state after reset
`define ENIGMA_LFSR_SEED 6'b000001

// cycles from encrypt capture to code_valid
`define ENIGMA_LATENCY 5

`endif

// File: rtl/enigma_pkg.sv
/*
 * Enigma cipher package
 * character type and load table selector
 */

`default_nettype none

`include "enigma_consts.svh"

package enigma_pkg;

  // one character, table entry or rotor offset
  typedef logic [`ENIGMA_CODE_W-1:0] code_t;

  // table_idx encoding while load is high
  typedef enum logic [1:0] {
    TBL_ROTOR = 2'b00,
    TBL_PLUG  = 2'b01
  } table_sel_t;

endpackage

`default_nettype wire

// File: rtl/enigma_plugboard.sv
/*
 * Enigma plugboard
 * shift-loaded pair table, forward and return lookups of one cycle each
 */

`timescale 1ns/1ps
`default_nettype none

`include "enigma_consts.svh"

module enigma_plugboard import enigma_pkg::*; (
  input  logic  clk,
  input  logic  srst_n,
  input  logic  we,
  input  logic  fwd_valid_in,
  input  logic  ret_valid_in,
  input  code_t wr_code,
  input  code_t fwd_in,
  input  code_t ret_in,
  output code_t fwd_out,
  output code_t ret_out,
  output logic  fwd_valid,
  output logic  ret_valid
);

  code_t table_q [`ENIGMA_PLUG_DEPTH];

  // partner of a matching entry, unmatched values pass through
  // entries i and i^1 were loaded back to back and form a pair
  function automatic code_t pair_of(input code_t key);
    code_t partner;
    partner = key;
    for (int i = 0; i < `ENIGMA_PLUG_DEPTH; i++) begin
      if (table_q[i] == key) begin
        partner = table_q[i ^ 1];
      end
    end
    return partner;
  endfunction

  // ==========================================================================
  // table load
  // ==========================================================================

  // new code enters at entry 0, older ones move up
  always_ff @(posedge clk) begin
    if (we) begin
      table_q[0] <= wr_code;
      for (int i = 1; i < `ENIGMA_PLUG_DEPTH; i++) begin
        table_q[i] <= table_q[i-1];
      end
    end
  end

  // ==========================================================================
  // lookups
  // ==========================================================================

  always_ff @(posedge clk) begin
    fwd_out <= pair_of(fwd_in);
    ret_out <= pair_of(ret_in);
  end

  always_ff @(posedge clk) begin
    if (!srst_n) begin
      fwd_valid <= 1'b0;
      ret_valid <= 1'b0;
    end else begin
      fwd_valid <= fwd_valid_in;
      ret_valid <= ret_valid_in;
    end
  end

  // a character must not start while the table is still shifting
  a_no_start_during_load: assert property (
    @(posedge clk) disable iff (!srst_n)
    $rose(fwd_valid_in) |-> !we
  ) else $error("plugboard: character started during table load");

endmodule

`default_nettype wire

// File: rtl/enigma_rotor.sv
/*
 * Enigma rotor
 * shift-loaded 64-entry table, stepping offset, forward read and
 * inverse search with the character's own offset removed
 */

`timescale 1ns/1ps
`default_nettype none

`include "enigma_consts.svh"

module enigma_rotor import enigma_pkg::*; (
  input  logic  clk,
  input  logic  srst_n,
  input  logic  we,
  input  logic  fwd_valid_in,
  input  logic  inv_valid_in,
  input  code_t wr_code,
  input  code_t fwd_in,
  input  code_t inv_in,
  output code_t fwd_out,
  output code_t inv_out,
  output logic  fwd_valid,
  output logic  inv_valid
);

  code_t table_q [`ENIGMA_ROTOR_DEPTH];
  code_t offset_q;
  code_t rd_addr;
  code_t inv_idx;
  code_t inv_idx_q;

  // offset per character, one slot per stage between read and subtract
  code_t off_dly_q [2];

  // ==========================================================================
  // table load
  // ==========================================================================

  // entry i ends up holding the i-th loaded code
  always_ff @(posedge clk) begin
    if (we) begin
      table_q[`ENIGMA_ROTOR_DEPTH-1] <= wr_code;
      for (int i = 0; i < `ENIGMA_ROTOR_DEPTH - 1; i++) begin
        table_q[i] <= table_q[i+1];
      end
    end
  end

  // ==========================================================================
  // forward path
  // ==========================================================================

  // wraps mod 64 through the code width
  assign rd_addr = fwd_in + offset_q;

  always_ff @(posedge clk) begin
    fwd_out <= table_q[rd_addr];
  end

  // one step per character, idle cycles leave it alone
  always_ff @(posedge clk) begin
    if (!srst_n) begin
      offset_q <= '0;
    end else if (fwd_valid_in) begin
      offset_q <= offset_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    off_dly_q[0] <= offset_q;
    off_dly_q[1] <= off_dly_q[0];
  end

  // ==========================================================================
  // inverse path
  // ==========================================================================

  // index holding inv_in, table is a permutation so one entry matches
  always_comb begin
    inv_idx = '0;
    for (int i = 0; i < `ENIGMA_ROTOR_DEPTH; i++) begin
      if (table_q[i] == inv_in) begin
        inv_idx = code_t'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    inv_idx_q <= inv_idx;
  end

  // undo the forward offset of this same character
  assign inv_out = inv_idx_q - off_dly_q[1];

  always_ff @(posedge clk) begin
    if (!srst_n) begin
      fwd_valid <= 1'b0;
      inv_valid <= 1'b0;
    end else begin
      fwd_valid <= fwd_valid_in;
      inv_valid <= inv_valid_in;
    end
  end

  // reflected character comes back exactly one stage after the forward read
  // otherwise off_dly_q[1] would belong to another character
  a_inv_follows_fwd: assert property (
    @(posedge clk) disable iff (!srst_n)
    inv_valid_in == $past(fwd_valid_in)
  ) else $error("rotor: inverse input out of step with forward path");

endmodule

`default_nettype wire

// File: rtl/enigma_top.sv
/*
 * Enigma cipher top
 * input registers, table write decode, five-stage character pipeline
 * (plugboard, rotor, reflector, rotor inverse, plugboard) and output register
 */

`timescale 1ns/1ps
`default_nettype none

`include "enigma_consts.svh"

module enigma_top import enigma_pkg::*; (
  input  logic       clk,
  input  logic       srst_n,
  input  logic       load,
  input  logic       encrypt,
  input  table_sel_t table_idx,
  input  code_t      code_in,
  output code_t      code_out,
  output logic       code_valid
);

  logic       load_q;
  logic       encrypt_q;
  table_sel_t table_idx_q;
  code_t      code_in_q;

  logic       rotor_we;
  logic       plug_we;

  code_t      plug_fwd_out;
  code_t      plug_ret_out;
  logic       plug_fwd_valid;
  logic       plug_ret_valid;
  code_t      rot_fwd_out;
  code_t      rot_inv_out;
  logic       rot_fwd_valid;
  logic       rot_inv_valid;
  code_t      wht_out;
  logic       wht_valid;

  // ==========================================================================
  // input registers and write decode
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (!srst_n) begin
      load_q    <= 1'b0;
      encrypt_q <= 1'b0;
    end else begin
      load_q    <= load;
      encrypt_q <= encrypt;
    end
  end

  always_ff @(posedge clk) begin
    table_idx_q <= table_idx;
    code_in_q   <= code_in;
  end

  assign rotor_we = load_q && (table_idx_q == TBL_ROTOR);
  assign plug_we  = load_q && (table_idx_q == TBL_PLUG);

  // ==========================================================================
  // character pipeline
  // ==========================================================================

  enigma_plugboard u_plugboard (
    .clk          (clk),
    .srst_n       (srst_n),
    .we           (plug_we),
    .fwd_valid_in (encrypt_q),
    .ret_valid_in (rot_inv_valid),
    .wr_code      (code_in_q),
    .fwd_in       (code_in_q),
    .ret_in       (rot_inv_out),
    .fwd_out      (plug_fwd_out),
    .ret_out      (plug_ret_out),
    .fwd_valid    (plug_fwd_valid),
    .ret_valid    (plug_ret_valid)
  );

  enigma_rotor u_rotor (
    .clk          (clk),
    .srst_n       (srst_n),
    .we           (rotor_we),
    .fwd_valid_in (plug_fwd_valid),
    .inv_valid_in (wht_valid),
    .wr_code      (code_in_q),
    .fwd_in       (plug_fwd_out),
    .inv_in       (wht_out),
    .fwd_out      (rot_fwd_out),
    .inv_out      (rot_inv_out),
    .fwd_valid    (rot_fwd_valid),
    .inv_valid    (rot_inv_valid)
  );

  // reflector sits between rotor forward and rotor inverse
  enigma_whitening u_whitening (
    .clk      (clk),
    .srst_n   (srst_n),
    .valid_in (rot_fwd_valid),
    .din      (rot_fwd_out),
    .dout     (wht_out),
    .valid    (wht_valid)
  );

  always_ff @(posedge clk) begin
    code_out <= plug_ret_out;
  end

  always_ff @(posedge clk) begin
    if (!srst_n) begin
      code_valid <= 1'b0;
    end else begin
      code_valid <= plug_ret_valid;
    end
  end

  // ==========================================================================
  // protocol checks
  // ==========================================================================

  a_load_encrypt_excl: assert property (
    @(posedge clk) disable iff (!srst_n)
    !(load && encrypt)
  ) else $error("top: load and encrypt high together");

  a_table_idx_legal: assert property (
    @(posedge clk) disable iff (!srst_n)
    load |-> (table_idx inside {TBL_ROTOR, TBL_PLUG})
  ) else $error("top: illegal table_idx during load");

endmodule

`default_nettype wire

// File: rtl/enigma_whitening.sv
/*
 * Enigma reflector
 * XORs each character with a 6-bit LFSR that steps per character
 */

`timescale 1ns/1ps
`default_nettype none

`include "enigma_consts.svh"

module enigma_whitening import enigma_pkg::*; (
  input  logic  clk,
  input  logic  srst_n,
  input  logic  valid_in,
  input  code_t din,
  output code_t dout,
  output logic  valid
);

  code_t state_q;
  logic  feedback;

  // taps on the two top bits
  assign feedback = state_q[`ENIGMA_CODE_W-2] ^ state_q[`ENIGMA_CODE_W-1];

  always_ff @(posedge clk) begin
    if (!srst_n) begin
      state_q <= `ENIGMA_LFSR_SEED;
    end else if (valid_in) begin
      state_q <= {state_q[`ENIGMA_CODE_W-2:0], feedback};
    end
  end

  // no register here, the rotor inverse stage captures the result
  assign dout  = din ^ state_q;
  assign valid = valid_in;

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the enigma cipher testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  -Wno-fatal \
  --top-module enigma_tb \
  -f flist.f \
  -o Venigma_tb

./obj_dir/Venigma_tb 2>&1 | tee sim.log

if grep -qx "all tests passed" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi

// File: sim/enigma_tb.sv
/*
 * Enigma cipher testbench
 * random tables, latency and value checks against a reference model,
 * reciprocity after a second reset
 */

`timescale 1ns/1ps
`default_nettype none

`include "enigma_consts.svh"

module enigma_tb import enigma_pkg::*; ();

  localparam int LAT       = `ENIGMA_LATENCY;
  localparam int ROT_N     = `ENIGMA_ROTOR_DEPTH;
  localparam int PLUG_N    = `ENIGMA_PLUG_DEPTH;
  localparam int RST_CYC   = 4;
  localparam int N_SPACED  = 4;
  localparam int N_BURST   = 64;
  localparam int N_GAPPED  = 32;
  localparam int MAX_GAP   = 3;
  localparam int N_OPEN    = 16;
  localparam int N_TOTAL   = N_SPACED + N_BURST + N_GAPPED + N_OPEN;
  localparam int LOAD_CYC  = ROT_N + PLUG_N + 2;
  localparam int STIM_CYC  = (RST_CYC + LOAD_CYC + N_SPACED * (LAT + 2))
                           + N_BURST + N_GAPPED * (MAX_GAP + 1) + N_OPEN
                           + (RST_CYC + LOAD_CYC + N_TOTAL);
  localparam int NUM_TESTS = 5;
  localparam int LIMIT_CYC = 2 * STIM_CYC + NUM_TESTS * LAT;

  logic       clk;
  logic       srst_n;
  logic       load;
  logic       encrypt;
  table_sel_t table_idx;
  code_t      code_in;
  code_t      code_out;
  logic       code_valid;

  // tables in load order, plus the set of plugboard values
  code_t rotor_tbl [ROT_N];
  code_t plug_tbl [PLUG_N];
  logic  in_plug [1 << `ENIGMA_CODE_W];
  code_t model_off;
  code_t model_lfsr;

  code_t exp_q [$];
  code_t plain_q [$];
  code_t cipher_q [$];

  // issue history, one slot per pipeline stage
  logic [LAT:0] vld_hist;
  code_t        exp_hist [LAT+1];

  int          err_count;
  int          test_num;
  int          failed_tests;
  int          cycle_count;

  enigma_top dut (
    .clk        (clk),
    .srst_n     (srst_n),
    .load       (load),
    .encrypt    (encrypt),
    .table_idx  (table_idx),
    .code_in    (code_in),
    .code_out   (code_out),
    .code_valid (code_valid)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < LIMIT_CYC) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: run did not finish within %0d cycles", LIMIT_CYC);
    $display("tests failed");
    $finish;
  end

  // ==========================================================================
  // reference model
  // ==========================================================================

  function automatic code_t rand_code();
    logic [31:0] r;
    r = $urandom();
    return r[`ENIGMA_CODE_W-1:0];
  endfunction

  // 1st value loaded pairs with the 2nd, 3rd with 4th
  function automatic code_t plug_pair(input code_t x);
    for (int k = 0; k < PLUG_N; k++) begin
      if (plug_tbl[k] == x) begin
        return plug_tbl[k ^ 1];
      end
    end
    return x;
  endfunction

  function automatic code_t rotor_index(input code_t y);
    for (int i = 0; i < ROT_N; i++) begin
      if (rotor_tbl[i] == y) begin
        return code_t'(i);
      end
    end
    return '0;
  endfunction

  // one character through the model, steps offset and lfsr
  function automatic code_t model_step(input code_t pt);
    code_t p;
    code_t fwd;
    code_t refl;
    code_t back;
    p          = plug_pair(pt);
    fwd        = rotor_tbl[code_t'(p + model_off)];
    refl       = fwd ^ model_lfsr;
    back       = rotor_index(refl) - model_off;
    model_off  = model_off + 1'b1;
    model_lfsr = {model_lfsr[4:0], model_lfsr[4] ^ model_lfsr[5]};
    return plug_pair(back);
  endfunction

  // rotor is a shuffled identity, plugboard 32 distinct values
  task automatic make_tables();
    int    j;
    code_t tmp;
    code_t v;
    for (int i = 0; i < ROT_N; i++) begin
      rotor_tbl[i] = code_t'(i);
    end
    for (int i = ROT_N - 1; i > 0; i--) begin
      j            = int'($urandom % (i + 1));
      tmp          = rotor_tbl[i];
      rotor_tbl[i] = rotor_tbl[j];
      rotor_tbl[j] = tmp;
    end
    for (int i = 0; i < (1 << `ENIGMA_CODE_W); i++) begin
      in_plug[i] = 1'b0;
    end
    for (int k = 0; k < PLUG_N; k++) begin
      v = rand_code();
      while (in_plug[v]) begin
        v = rand_code();
      end
      in_plug[v]  = 1'b1;
      plug_tbl[k] = v;
    end
  endtask

  // ==========================================================================
  // stimulus
  // ==========================================================================

  task automatic apply_reset();
    srst_n  <= 1'b0;
    load    <= 1'b0;
    encrypt <= 1'b0;
    repeat (RST_CYC) @(posedge clk);
    srst_n     <= 1'b1;
    model_off  = '0;
    model_lfsr = `ENIGMA_LFSR_SEED;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      load    <= 1'b0;
      encrypt <= 1'b0;
    end
  endtask

  task automatic load_entry(input table_sel_t sel, input code_t val);
    @(posedge clk);
    encrypt   <= 1'b0;
    load      <= 1'b1;
    table_idx <= sel;
    code_in   <= val;
  endtask

  task automatic load_tables();
    for (int i = 0; i < ROT_N; i++) begin
      load_entry(TBL_ROTOR, rotor_tbl[i]);
    end
    for (int k = 0; k < PLUG_N; k++) begin
      load_entry(TBL_PLUG, plug_tbl[k]);
    end
    idle_cycles(2);
  endtask

  task automatic send_char(input code_t c, input code_t expected);
    @(posedge clk);
    load    <= 1'b0;
    encrypt <= 1'b1;
    code_in <= c;
    exp_q.push_back(expected);
  endtask

  task automatic encipher(input code_t pt);
    send_char(pt, model_step(pt));
    plain_q.push_back(pt);
  endtask

  task automatic wait_drain();
    @(posedge clk);
    while (exp_q.size() != 0 || vld_hist != '0) begin
      @(posedge clk);
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    int errs;
    wait_drain();
    errs = err_count - errs_before;
    test_num++;
    if (errs == 0) begin
      $display("test %0d %s: ok", test_num, name);
    end else begin
      $display("test %0d %s: FAILED with %0d errors", test_num, name, errs);
      failed_tests++;
    end
  endtask

  // ==========================================================================
  // checking
  // ==========================================================================

  always @(posedge clk) begin
    if (!srst_n) begin
      vld_hist <= '0;
    end else begin
      vld_hist <= {vld_hist[LAT-1:0], encrypt};
      if (encrypt && exp_q.size() > 0) begin
        exp_hist[0] <= exp_q.pop_front();
      end
      for (int k = 1; k <= LAT; k++) begin
        exp_hist[k] <= exp_hist[k-1];
      end
      if (code_valid) begin
        cipher_q.push_back(code_out);
      end
    end
  end

  a_valid_timing: assert property (
    @(posedge clk) disable iff (!srst_n)
    code_valid == vld_hist[LAT]
  ) else begin
    $display("[ERROR] %0t code_valid expected %b got %b",
             $time, $sampled(vld_hist[LAT]), $sampled(code_valid));
    err_count++;
  end

  a_code_value: assert property (
    @(posedge clk) disable iff (!srst_n)
    vld_hist[LAT] |-> (code_out == exp_hist[LAT])
  ) else begin
    $display("[ERROR] %0t code_out expected %h got %h",
             $time, $sampled(exp_hist[LAT]), $sampled(code_out));
    err_count++;
  end

  a_quiet_load: assert property (
    @(posedge clk) disable iff (!srst_n)
    load |-> !code_valid
  ) else begin
    $display("[ERROR] %0t code_valid expected 0 got 1 during table load", $time);
    err_count++;
  end

  // ==========================================================================
  // tests
  // ==========================================================================

  initial begin
    int    errs_before;
    int    gap;
    code_t pt;
    code_t ct_q [$];
    code_t pt_q [$];
    srst_n       = 1'b0;
    load         = 1'b0;
    encrypt      = 1'b0;
    table_idx    = TBL_ROTOR;
    code_in      = '0;
    err_count    = 0;
    test_num     = 0;
    failed_tests = 0;
    void'($urandom(32'h155a_a9c1));
    make_tables();

    errs_before = err_count;
    apply_reset();
    load_tables();
    for (int i = 0; i < N_SPACED; i++) begin
      encipher(rand_code());
      idle_cycles(LAT + 1);
    end
    end_test("load and latency", errs_before);

    errs_before = err_count;
    for (int i = 0; i < N_BURST; i++) begin
      encipher(rand_code());
    end
    idle_cycles(1);
    end_test("burst of 64", errs_before);

    // offset and lfsr must hold still over idle cycles
    errs_before = err_count;
    for (int i = 0; i < N_GAPPED; i++) begin
      encipher(rand_code());
      gap = int'($urandom % (MAX_GAP + 1));
      idle_cycles(gap);
    end
    idle_cycles(1);
    end_test("random gaps", errs_before);

    errs_before = err_count;
    for (int i = 0; i < N_OPEN; i++) begin
      pt = rand_code();
      while (in_plug[pt]) begin
        pt = rand_code();
      end
      encipher(pt);
    end
    idle_cycles(1);
    end_test("values off the plugboard", errs_before);

    // same tables from reset, ciphertext in, plaintext out
    errs_before = err_count;
    ct_q        = cipher_q;
    pt_q        = plain_q;
    if (ct_q.size() != pt_q.size()) begin
      $display("recorded %0d ciphertext characters for %0d plaintext characters",
               ct_q.size(), pt_q.size());
      err_count++;
    end
    apply_reset();
    load_tables();
    for (int i = 0; i < ct_q.size() && i < pt_q.size(); i++) begin
      send_char(ct_q[i], pt_q[i]);
    end
    idle_cycles(1);
    end_test("reciprocity", errs_before);

    $display("summary: %0d tests, %0d passed, %0d with errors, %0d errors in all",
             test_num, test_num - failed_tests, failed_tests, err_count);
    if (failed_tests == 0 && err_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
